// File: all.f
+incdir+hw
hw/reg_pkg.sv
hw/reg_control.sv
hw/reg_file.sv
hw/reg_bus_mux.sv
hw/reg_unit.sv
tests/reg_unit_checker.sv
tests/reg_unit_tb.sv

// File: hw/reg_bus_mux.sv
/* data bus driver: lane enables and byte steering
   from the gp and system read ports onto the output lanes */

`include "reg_defs.svh"

module reg_bus_mux (
    input  logic [`REG_PAIR_W-1:0] gp_rd_pair,
    input  logic [`REG_PAIR_W-1:0] sys_rd_pair,
    input  logic                   reg_sel_gp_hi,
    input  logic                   reg_sel_gp_lo,
    input  logic                   reg_sel_sys_hi,
    input  logic                   reg_sel_sys_lo,
    input  logic                   reg_gp_oe,
    input  logic                   reg_sys_oe,
    output logic [`REG_DATA_W-1:0] db_hi_out,
    output logic [`REG_DATA_W-1:0] db_lo_out,
    output logic                   db_hi_oe,
    output logic                   db_lo_oe
);

    logic gp_hi_en, gp_lo_en;           // gp port owns the lane
    logic sys_hi_en, sys_lo_en;         // sys port owns the lane

    // byte for one lane, zero when nobody drives it
    function automatic logic [`REG_DATA_W-1:0] lane_byte(
        input logic                   gp_en,
        input logic                   sys_en,
        input logic [`REG_DATA_W-1:0] gp_byte,
        input logic [`REG_DATA_W-1:0] sys_byte
    );
        if (gp_en)
            return gp_byte;
        else if (sys_en)
            return sys_byte;
        return '0;
    endfunction

    // ----------------------------------------------------------
    // lane enables
    // ----------------------------------------------------------
    assign gp_hi_en  = reg_gp_oe & reg_sel_gp_hi;
    assign gp_lo_en  = reg_gp_oe & reg_sel_gp_lo;
    assign sys_hi_en = reg_sys_oe & reg_sel_sys_hi;
    assign sys_lo_en = reg_sys_oe & reg_sel_sys_lo;

    assign db_hi_oe = gp_hi_en | sys_hi_en;
    assign db_lo_oe = gp_lo_en | sys_lo_en;

    // ----------------------------------------------------------
    // lane data
    // ----------------------------------------------------------
    assign db_hi_out = lane_byte(gp_hi_en, sys_hi_en,
                                 gp_rd_pair[`REG_PAIR_W-1:`REG_DATA_W],
                                 sys_rd_pair[`REG_PAIR_W-1:`REG_DATA_W]);
    assign db_lo_out = lane_byte(gp_lo_en, sys_lo_en,
                                 gp_rd_pair[`REG_DATA_W-1:0],
                                 sys_rd_pair[`REG_DATA_W-1:0]);

endmodule

// File: hw/reg_control.sv
/* register control: exchange flops and decode of selector and strobes
   into one-hot physical pair selects, lane selects, enables and write */

`include "reg_defs.svh"

module reg_control import reg_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  gp_sel_e reg_sel,            // B..F code
    input  logic    ctl_reg_exx,        // exx pulse
    input  logic    ctl_reg_ex_af,      // ex af,af' pulse
    input  logic    ctl_reg_ex_de_hl,   // ex de,hl pulse
    input  logic    ctl_reg_use_ixiy,   // index reg replaces hl
    input  logic    ctl_reg_use_ix,     // ix rather than iy
    input  logic    ctl_reg_use_sp,     // sp replaces af
    input  logic    ctl_reg_sel_gp,
    input  logic    ctl_reg_sel_gp_16,  // both lanes
    input  logic    ctl_reg_sel_wz,
    input  logic    ctl_reg_sel_pc,
    input  logic    ctl_reg_sel_ir,
    input  logic    ctl_reg_sel_sys_hi,
    input  logic    ctl_reg_sel_sys_lo,
    input  logic    ctl_reg_gp_oe,
    input  logic    ctl_reg_sys_oe,
    input  logic    ctl_sw_4d,          // downstream switch, write strobe
    output logic    reg_sel_af,
    output logic    reg_sel_af2,
    output logic    reg_sel_bc,
    output logic    reg_sel_bc2,
    output logic    reg_sel_de,
    output logic    reg_sel_de2,
    output logic    reg_sel_hl,
    output logic    reg_sel_hl2,
    output logic    reg_sel_ix,
    output logic    reg_sel_iy,
    output logic    reg_sel_sp,
    output logic    reg_sel_wz,
    output logic    reg_sel_pc,
    output logic    reg_sel_ir,
    output logic    reg_sel_gp_hi,
    output logic    reg_sel_gp_lo,
    output logic    reg_sel_sys_hi,
    output logic    reg_sel_sys_lo,
    output logic    reg_gp_oe,
    output logic    reg_sys_oe,
    output logic    reg_we
);

    bank_e exx_bank;                    // main or alt bc/de/hl
    bank_e af_bank;                     // main or alt af
    bank_e de_hl_swap [2];              // one swap flop per exx bank

    logic  log_bc, log_de, log_hl, log_af;  // pair named by the selector
    logic  swp_de, swp_hl;              // after de/hl swap
    logic  alt_exx, alt_af, swap_on;
    logic  use_idx;
    logic  sys_any;

    function automatic bank_e flip(input bank_e b);
        return (b == BANK_MAIN) ? BANK_ALT : BANK_MAIN;
    endfunction

    // ----------------------------------------------------------
    // exchange flops
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exx_bank      <= BANK_MAIN;
            af_bank       <= BANK_MAIN;
            de_hl_swap[0] <= BANK_MAIN;
            de_hl_swap[1] <= BANK_MAIN;
        end else begin
            if (ctl_reg_exx)
                exx_bank <= flip(exx_bank);
            if (ctl_reg_ex_af)
                af_bank <= flip(af_bank);
            if (ctl_reg_ex_de_hl)   // only the bank in use at the edge
                de_hl_swap[exx_bank] <= flip(de_hl_swap[exx_bank]);
        end
    end

    assign alt_exx = (exx_bank == BANK_ALT);
    assign alt_af  = (af_bank == BANK_ALT);
    assign swap_on = (de_hl_swap[exx_bank] == BANK_ALT);

    // ----------------------------------------------------------
    // gp decode
    // ----------------------------------------------------------
    always_comb begin
        log_bc = 1'b0;
        log_de = 1'b0;
        log_hl = 1'b0;
        log_af = 1'b0;
        if (ctl_reg_sel_gp) begin
            unique case (reg_sel)
                SEL_B, SEL_C: log_bc = 1'b1;
                SEL_D, SEL_E: log_de = 1'b1;
                SEL_H, SEL_L: log_hl = 1'b1;
                default:      log_af = 1'b1;    // A, F
            endcase
        end
    end

    assign swp_de  = swap_on ? log_hl : log_de;
    assign swp_hl  = swap_on ? log_de : log_hl;
    assign use_idx = swp_hl & ctl_reg_use_ixiy;     // substitution after the swap

    assign reg_sel_bc  = log_bc & ~alt_exx;
    assign reg_sel_bc2 = log_bc &  alt_exx;
    assign reg_sel_de  = swp_de & ~alt_exx;
    assign reg_sel_de2 = swp_de &  alt_exx;
    assign reg_sel_hl  = swp_hl & ~ctl_reg_use_ixiy & ~alt_exx;
    assign reg_sel_hl2 = swp_hl & ~ctl_reg_use_ixiy &  alt_exx;
    assign reg_sel_ix  = use_idx &  ctl_reg_use_ix;
    assign reg_sel_iy  = use_idx & ~ctl_reg_use_ix;
    assign reg_sel_sp  = log_af &  ctl_reg_use_sp;
    assign reg_sel_af  = log_af & ~ctl_reg_use_sp & ~alt_af;
    assign reg_sel_af2 = log_af & ~ctl_reg_use_sp &  alt_af;

    // gp lanes, bit 0 low means high byte
    assign reg_sel_gp_hi = ctl_reg_sel_gp & (ctl_reg_sel_gp_16 | ~reg_sel[0]);
    assign reg_sel_gp_lo = ctl_reg_sel_gp & (ctl_reg_sel_gp_16 |  reg_sel[0]);

    // ----------------------------------------------------------
    // system pairs, direct selects
    // ----------------------------------------------------------
    assign reg_sel_wz     = ctl_reg_sel_wz;
    assign reg_sel_pc     = ctl_reg_sel_pc;
    assign reg_sel_ir     = ctl_reg_sel_ir;
    assign reg_sel_sys_hi = ctl_reg_sel_sys_hi;
    assign reg_sel_sys_lo = ctl_reg_sel_sys_lo;
    assign sys_any        = ctl_reg_sel_wz | ctl_reg_sel_pc | ctl_reg_sel_ir;

    // enables and write only with something selected
    assign reg_gp_oe  = ctl_reg_gp_oe & ctl_reg_sel_gp;
    assign reg_sys_oe = ctl_reg_sys_oe & sys_any;
    assign reg_we     = ctl_sw_4d & (ctl_reg_sel_gp | sys_any);

endmodule

// File: hw/reg_defs.svh
/* widths and counts shared by the register section
   data lane, register pair, gp selector and physical pair count */

`ifndef REG_DEFS_SVH
`define REG_DEFS_SVH

// ----------------------------------------------------------
// data path widths
// ----------------------------------------------------------

`define REG_DATA_W 8                    // one byte lane of the data bus

`define REG_PAIR_W 16                   // hi and lo byte of a pair

// ----------------------------------------------------------
// selection
// ----------------------------------------------------------

`define REG_SEL_W 3                     // gp selector: B C D E H L A F

// af, bc, de, hl in both banks, plus ix, iy, sp, wz, pc, ir
`define REG_NUM_PAIRS 14

`endif

// File: hw/reg_file.sv
/* register file: storage of all physical pairs, byte-lane writes,
   one gp read port and one system read port */

`include "reg_defs.svh"

module reg_file import reg_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   reg_sel_af,
    input  logic                   reg_sel_af2,
    input  logic                   reg_sel_bc,
    input  logic                   reg_sel_bc2,
    input  logic                   reg_sel_de,
    input  logic                   reg_sel_de2,
    input  logic                   reg_sel_hl,
    input  logic                   reg_sel_hl2,
    input  logic                   reg_sel_ix,
    input  logic                   reg_sel_iy,
    input  logic                   reg_sel_sp,
    input  logic                   reg_sel_wz,
    input  logic                   reg_sel_pc,
    input  logic                   reg_sel_ir,
    input  logic                   reg_sel_gp_hi,
    input  logic                   reg_sel_gp_lo,
    input  logic                   reg_sel_sys_hi,
    input  logic                   reg_sel_sys_lo,
    input  logic                   reg_we,
    input  logic [`REG_DATA_W-1:0] db_hi_in,
    input  logic [`REG_DATA_W-1:0] db_lo_in,
    output logic [`REG_PAIR_W-1:0] gp_rd_pair,
    output logic [`REG_PAIR_W-1:0] sys_rd_pair
);

    localparam int N = `REG_NUM_PAIRS;

    // pairs written through the system lane selects
    localparam logic [N-1:0] SYS_MASK = (N'(1) << PAIR_WZ) |
                                        (N'(1) << PAIR_PC) |
                                        (N'(1) << PAIR_IR);

    logic [`REG_PAIR_W-1:0] regs [N];   // indexed by pair_e
    logic [N-1:0]           pair_sel;   // one-hot gp + one-hot sys
    logic [N-1:0]           wr_hi;
    logic [N-1:0]           wr_lo;

    // ----------------------------------------------------------
    // select vector in pair_e order
    // ----------------------------------------------------------
    always_comb begin
        pair_sel           = '0;
        pair_sel[PAIR_AF]  = reg_sel_af;
        pair_sel[PAIR_AF2] = reg_sel_af2;
        pair_sel[PAIR_BC]  = reg_sel_bc;
        pair_sel[PAIR_BC2] = reg_sel_bc2;
        pair_sel[PAIR_DE]  = reg_sel_de;
        pair_sel[PAIR_DE2] = reg_sel_de2;
        pair_sel[PAIR_HL]  = reg_sel_hl;
        pair_sel[PAIR_HL2] = reg_sel_hl2;
        pair_sel[PAIR_IX]  = reg_sel_ix;
        pair_sel[PAIR_IY]  = reg_sel_iy;
        pair_sel[PAIR_SP]  = reg_sel_sp;
        pair_sel[PAIR_WZ]  = reg_sel_wz;
        pair_sel[PAIR_PC]  = reg_sel_pc;
        pair_sel[PAIR_IR]  = reg_sel_ir;
    end

    // byte enables per pair, lane select by pair class
    assign wr_hi = pair_sel & ((SYS_MASK & {N{reg_sel_sys_hi}}) |
                               (~SYS_MASK & {N{reg_sel_gp_hi}}));
    assign wr_lo = pair_sel & ((SYS_MASK & {N{reg_sel_sys_lo}}) |
                               (~SYS_MASK & {N{reg_sel_gp_lo}}));

    // ----------------------------------------------------------
    // storage
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N; i++)
                regs[i] <= '0;          // all pairs start at zero
        end else if (reg_we) begin
            for (int i = 0; i < N; i++) begin
                if (wr_hi[i])
                    regs[i][`REG_PAIR_W-1:`REG_DATA_W] <= db_hi_in;
                if (wr_lo[i])
                    regs[i][`REG_DATA_W-1:0] <= db_lo_in;
            end
        end
    end

    // ----------------------------------------------------------
    // read ports, or of one-hot selected pairs
    // ----------------------------------------------------------
    always_comb begin
        gp_rd_pair  = '0;
        sys_rd_pair = '0;
        for (int i = 0; i < N; i++) begin
            if (pair_sel[i] && !SYS_MASK[i])
                gp_rd_pair = gp_rd_pair | regs[i];
            if (pair_sel[i] && SYS_MASK[i])
                sys_rd_pair = sys_rd_pair | regs[i];
        end
    end

endmodule

// File: hw/reg_pkg.sv
/* register section types
   gp selector codes, physical pair index and exchange bank state */

`include "reg_defs.svh"

package reg_pkg;

    // ----------------------------------------------------------
    // gp selector, upper bits pick the pair, bit 0 picks the byte
    // ----------------------------------------------------------
    typedef enum logic [`REG_SEL_W-1:0] {
        SEL_B = 3'b000,                 // bc high
        SEL_C = 3'b001,                 // bc low
        SEL_D = 3'b010,                 // de high
        SEL_E = 3'b011,                 // de low
        SEL_H = 3'b100,                 // hl high
        SEL_L = 3'b101,                 // hl low
        SEL_A = 3'b110,                 // af high
        SEL_F = 3'b111                  // af low
    } gp_sel_e;

    // physical pairs as stored in the register file
    typedef enum logic [$clog2(`REG_NUM_PAIRS)-1:0] {
        PAIR_AF, PAIR_AF2,
        PAIR_BC, PAIR_BC2,
        PAIR_DE, PAIR_DE2,
        PAIR_HL, PAIR_HL2,
        PAIR_IX, PAIR_IY,
        PAIR_SP,
        PAIR_WZ, PAIR_PC, PAIR_IR       // system pairs, own lane selects
    } pair_e;

    // state of one exchange flop
    typedef enum logic {
        BANK_MAIN = 1'b0,
        BANK_ALT  = 1'b1
    } bank_e;

endpackage

// File: hw/reg_unit.sv
/* register section top: control, register file and data bus driver */

`include "reg_defs.svh"

module reg_unit import reg_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  gp_sel_e                reg_sel,
    input  logic                   ctl_reg_exx,
    input  logic                   ctl_reg_ex_af,
    input  logic                   ctl_reg_ex_de_hl,
    input  logic                   ctl_reg_use_ixiy,
    input  logic                   ctl_reg_use_ix,
    input  logic                   ctl_reg_use_sp,
    input  logic                   ctl_reg_sel_gp,
    input  logic                   ctl_reg_sel_gp_16,
    input  logic                   ctl_reg_sel_wz,
    input  logic                   ctl_reg_sel_pc,
    input  logic                   ctl_reg_sel_ir,
    input  logic                   ctl_reg_sel_sys_hi,
    input  logic                   ctl_reg_sel_sys_lo,
    input  logic                   ctl_reg_gp_oe,
    input  logic                   ctl_reg_sys_oe,
    input  logic                   ctl_sw_4d,
    input  logic [`REG_DATA_W-1:0] db_hi_in,
    input  logic [`REG_DATA_W-1:0] db_lo_in,
    output logic [`REG_DATA_W-1:0] db_hi_out,
    output logic [`REG_DATA_W-1:0] db_lo_out,
    output logic                   db_hi_oe,
    output logic                   db_lo_oe
);

    // ----------------------------------------------------------
    // control to file and bus driver
    // ----------------------------------------------------------
    logic reg_sel_af, reg_sel_af2, reg_sel_bc, reg_sel_bc2;
    logic reg_sel_de, reg_sel_de2, reg_sel_hl, reg_sel_hl2;
    logic reg_sel_ix, reg_sel_iy, reg_sel_sp;
    logic reg_sel_wz, reg_sel_pc, reg_sel_ir;
    logic reg_sel_gp_hi, reg_sel_gp_lo;            // gp lanes
    logic reg_sel_sys_hi, reg_sel_sys_lo;          // system lanes
    logic reg_gp_oe, reg_sys_oe;
    logic reg_we;

    // file to bus driver
    logic [`REG_PAIR_W-1:0] gp_rd_pair;
    logic [`REG_PAIR_W-1:0] sys_rd_pair;

    reg_control reg_control_inst (.*);  // decode and exchange state

    reg_file reg_file_inst (.*);        // pair storage

    reg_bus_mux reg_bus_mux_inst (.*);  // output lanes

endmodule

// File: run.sh
#!/bin/sh
# build the register section testbench with verilator, run it, grep the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module reg_unit_tb -o reg_unit_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/reg_unit_tb +verilator+error+limit+10 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tests/reg_unit_checker.sv
/* bound checker: shadow register and bank model built from the top inputs,
   concurrent assertions on lane enables, lane data and stimulus legality */

`include "reg_defs.svh"

module reg_unit_checker import reg_pkg::*; (
    input logic                   clk,
    input logic                   arst_n,
    input gp_sel_e                reg_sel,
    input logic                   ctl_reg_exx, ctl_reg_ex_af, ctl_reg_ex_de_hl,
    input logic                   ctl_reg_use_ixiy, ctl_reg_use_ix, ctl_reg_use_sp,
    input logic                   ctl_reg_sel_gp, ctl_reg_sel_gp_16,
    input logic                   ctl_reg_sel_wz, ctl_reg_sel_pc, ctl_reg_sel_ir,
    input logic                   ctl_reg_sel_sys_hi, ctl_reg_sel_sys_lo,
    input logic                   ctl_reg_gp_oe, ctl_reg_sys_oe,
    input logic                   ctl_sw_4d,
    input logic [`REG_DATA_W-1:0] db_hi_in,
    input logic [`REG_DATA_W-1:0] db_lo_in,
    input logic [`REG_DATA_W-1:0] db_hi_out,
    input logic [`REG_DATA_W-1:0] db_lo_out,
    input logic                   db_hi_oe,
    input logic                   db_lo_oe
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`REG_PAIR_W-1:0] shadow [`REG_NUM_PAIRS];   // expected pair contents
    bank_e                  m_exx, m_af;
    bank_e                  m_swap [2];                 // per exx bank
    pair_e                  gp_pair, sys_pair;
    logic                   sys_any, gp_hi, gp_lo, gp_hi_en, gp_lo_en;
    logic                   exp_hi_oe, exp_lo_oe;
    logic [`REG_DATA_W-1:0] exp_hi, exp_lo;
    logic fail_hi_oe = 1'b0;
    logic fail_lo_oe = 1'b0;
    logic fail_hi    = 1'b0;
    logic fail_lo    = 1'b0;
    logic fail_legal = 1'b0;
    logic err_flag;                     // watched by the testbench

    // logical pair from selector bits, then swap, bank and substitution
    function automatic pair_e map_gp(input gp_sel_e sel, input bank_e exx, input bank_e af,
                                     input bank_e swp, input logic ixiy, input logic ix,
                                     input logic sp);
        logic [1:0] grp;
        logic       alt;
        grp = sel[2:1];                 // 0 bc, 1 de, 2 hl, 3 af
        alt = (exx == BANK_ALT);
        if (swp == BANK_ALT && (grp == 2'd1 || grp == 2'd2))
            grp = grp ^ 2'b11;          // de and hl trade places
        case (grp)
            2'd0: return alt ? PAIR_BC2 : PAIR_BC;
            2'd1: return alt ? PAIR_DE2 : PAIR_DE;
            2'd2: begin
                if (ixiy)
                    return ix ? PAIR_IX : PAIR_IY;
                return alt ? PAIR_HL2 : PAIR_HL;
            end
            default: begin
                if (sp)
                    return PAIR_SP;
                return (af == BANK_ALT) ? PAIR_AF2 : PAIR_AF;
            end
        endcase
    endfunction

    // ----------------------------------------------------------
    // decode from the top inputs
    // ----------------------------------------------------------
    assign gp_pair  = map_gp(reg_sel, m_exx, m_af, m_swap[m_exx],
                             ctl_reg_use_ixiy, ctl_reg_use_ix, ctl_reg_use_sp);
    assign sys_pair = ctl_reg_sel_pc ? PAIR_PC : (ctl_reg_sel_ir ? PAIR_IR : PAIR_WZ);
    assign sys_any  = ctl_reg_sel_wz | ctl_reg_sel_pc | ctl_reg_sel_ir;
    assign gp_hi    = ctl_reg_sel_gp & (ctl_reg_sel_gp_16 | ~reg_sel[0]);   // even code, hi
    assign gp_lo    = ctl_reg_sel_gp & (ctl_reg_sel_gp_16 |  reg_sel[0]);
    assign gp_hi_en = ctl_reg_gp_oe & gp_hi;
    assign gp_lo_en = ctl_reg_gp_oe & gp_lo;

    assign exp_hi_oe = gp_hi_en | (ctl_reg_sys_oe & sys_any & ctl_reg_sel_sys_hi);
    assign exp_lo_oe = gp_lo_en | (ctl_reg_sys_oe & sys_any & ctl_reg_sel_sys_lo);
    assign exp_hi = gp_hi_en ? shadow[gp_pair][`REG_PAIR_W-1:`REG_DATA_W] :
                    (exp_hi_oe ? shadow[sys_pair][`REG_PAIR_W-1:`REG_DATA_W] : '0);
    assign exp_lo = gp_lo_en ? shadow[gp_pair][`REG_DATA_W-1:0] :
                    (exp_lo_oe ? shadow[sys_pair][`REG_DATA_W-1:0] : '0);

    assign err_flag = fail_hi_oe | fail_lo_oe | fail_hi | fail_lo | fail_legal;

    // ----------------------------------------------------------
    // shadow state
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_NUM_PAIRS; i++)
                shadow[i] <= '0;
            m_exx     <= BANK_MAIN;
            m_af      <= BANK_MAIN;
            m_swap[0] <= BANK_MAIN;
            m_swap[1] <= BANK_MAIN;
        end else begin
            if (ctl_sw_4d && ctl_reg_sel_gp) begin
                if (gp_hi)
                    shadow[gp_pair][`REG_PAIR_W-1:`REG_DATA_W] <= db_hi_in;
                if (gp_lo)
                    shadow[gp_pair][`REG_DATA_W-1:0] <= db_lo_in;
            end
            if (ctl_sw_4d && sys_any) begin
                if (ctl_reg_sel_sys_hi)
                    shadow[sys_pair][`REG_PAIR_W-1:`REG_DATA_W] <= db_hi_in;
                if (ctl_reg_sel_sys_lo)
                    shadow[sys_pair][`REG_DATA_W-1:0] <= db_lo_in;
            end
            if (ctl_reg_exx)
                m_exx <= (m_exx == BANK_MAIN) ? BANK_ALT : BANK_MAIN;
            if (ctl_reg_ex_af)
                m_af <= (m_af == BANK_MAIN) ? BANK_ALT : BANK_MAIN;
            if (ctl_reg_ex_de_hl)       // bank in use before the edge
                m_swap[m_exx] <= (m_swap[m_exx] == BANK_MAIN) ? BANK_ALT : BANK_MAIN;
        end
    end

    // ----------------------------------------------------------
    // assertions
    // ----------------------------------------------------------
    a_hi_oe: assert property (@(posedge clk) disable iff (!arst_n) db_hi_oe == exp_hi_oe)
        else begin
            $error("[FAIL] hi_oe expected %b actual %b", $sampled(exp_hi_oe), $sampled(db_hi_oe));
            fail_hi_oe = 1'b1;
        end

    a_lo_oe: assert property (@(posedge clk) disable iff (!arst_n) db_lo_oe == exp_lo_oe)
        else begin
            $error("[FAIL] lo_oe expected %b actual %b", $sampled(exp_lo_oe), $sampled(db_lo_oe));
            fail_lo_oe = 1'b1;
        end

    a_hi_data: assert property (@(posedge clk) disable iff (!arst_n) db_hi_out == exp_hi)
        else begin
            $error("[FAIL] hi_data expected %h actual %h", $sampled(exp_hi), $sampled(db_hi_out));
            fail_hi = 1'b1;
        end

    a_lo_data: assert property (@(posedge clk) disable iff (!arst_n) db_lo_out == exp_lo)
        else begin
            $error("[FAIL] lo_data expected %h actual %h", $sampled(exp_lo), $sampled(db_lo_out));
            fail_lo = 1'b1;
        end

    // gp and system selection never overlap
    a_stim_legal: assert property (@(posedge clk) disable iff (!arst_n)
                                   !(ctl_reg_sel_gp && sys_any))
        else begin
            $error("[FAIL] stim_legal expected %b actual %b", 1'b0,
                   $sampled(ctl_reg_sel_gp && sys_any));
            fail_legal = 1'b1;
        end

endmodule

// File: tests/reg_unit_tb.sv
/* testbench for the register section: clock, reset, seeded stimulus,
   watchdog, final verdict; value checks come from the bound checker */

`include "reg_defs.svh"

module reg_unit_tb import reg_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 100;
    localparam int STIM_CYCLES   = 150;     // upper bound of the sequence below
    localparam int MARGIN_CYCLES = 20;

    logic                   clk = 1'b0;
    logic                   arst_n;
    gp_sel_e                reg_sel;
    logic                   ctl_reg_exx, ctl_reg_ex_af, ctl_reg_ex_de_hl;
    logic                   ctl_reg_use_ixiy, ctl_reg_use_ix, ctl_reg_use_sp;
    logic                   ctl_reg_sel_gp, ctl_reg_sel_gp_16;
    logic                   ctl_reg_sel_wz, ctl_reg_sel_pc, ctl_reg_sel_ir;
    logic                   ctl_reg_sel_sys_hi, ctl_reg_sel_sys_lo;
    logic                   ctl_reg_gp_oe, ctl_reg_sys_oe;
    logic                   ctl_sw_4d;
    logic [`REG_DATA_W-1:0] db_hi_in, db_lo_in;
    logic [`REG_DATA_W-1:0] db_hi_out, db_lo_out;
    logic                   db_hi_oe, db_lo_oe;
    logic [31:0]            rng_state = 32'h862df468;

    reg_unit reg_unit_inst (.*);

    bind reg_unit reg_unit_checker reg_unit_checker_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ----------------------------------------------------------
    // bus cycle tasks
    // ----------------------------------------------------------
    // next edge, all controls back to idle
    task automatic start_cycle();
        @(posedge clk);
        reg_sel            <= SEL_B;
        ctl_reg_exx        <= 1'b0;
        ctl_reg_ex_af      <= 1'b0;
        ctl_reg_ex_de_hl   <= 1'b0;
        {ctl_reg_use_ixiy, ctl_reg_use_ix, ctl_reg_use_sp} <= 3'b000;
        {ctl_reg_sel_gp, ctl_reg_sel_gp_16} <= 2'b00;
        {ctl_reg_sel_wz, ctl_reg_sel_pc, ctl_reg_sel_ir} <= 3'b000;
        {ctl_reg_sel_sys_hi, ctl_reg_sel_sys_lo} <= 2'b00;
        {ctl_reg_gp_oe, ctl_reg_sys_oe} <= 2'b00;
        ctl_sw_4d          <= 1'b0;
    endtask

    task automatic fresh_data();
        rng_state = xorshift32(rng_state);
        db_hi_in <= rng_state[15:8];
        db_lo_in <= rng_state[7:0];
    endtask

    // subst is {use_ixiy, use_ix, use_sp}; reads drive oe, writes leave it low
    task automatic gp_cycle(input logic [2:0] sel, input logic w16, input logic write,
                            input logic [2:0] subst);
        start_cycle();
        reg_sel           <= gp_sel_e'(sel);
        ctl_reg_sel_gp    <= 1'b1;
        ctl_reg_sel_gp_16 <= w16;
        ctl_reg_gp_oe     <= ~write;
        ctl_sw_4d         <= write;
        {ctl_reg_use_ixiy, ctl_reg_use_ix, ctl_reg_use_sp} <= subst;
        if (write)
            fresh_data();
    endtask

    // which: 0 wz, 1 pc, 2 ir
    task automatic sys_cycle(input logic [1:0] which, input logic hi, input logic lo,
                             input logic write);
        start_cycle();
        ctl_reg_sel_wz     <= (which == 2'd0);
        ctl_reg_sel_pc     <= (which == 2'd1);
        ctl_reg_sel_ir     <= (which == 2'd2);
        ctl_reg_sel_sys_hi <= hi;
        ctl_reg_sel_sys_lo <= lo;
        ctl_reg_sys_oe     <= ~write;
        ctl_sw_4d          <= write;
        if (write)
            fresh_data();
    endtask

    task automatic pulse(input logic exx, input logic ex_af, input logic ex_de_hl);
        start_cycle();
        ctl_reg_exx      <= exx;
        ctl_reg_ex_af    <= ex_af;
        ctl_reg_ex_de_hl <= ex_de_hl;
    endtask

    task automatic read_gp_pairs(input logic [2:0] subst);
        for (int p = 0; p < 8; p += 2)
            gp_cycle(3'(p), 1'b1, 1'b0, subst);     // B, D, H, A as 16 bit
    endtask

    task automatic write_read_gp(input logic [2:0] sel, input logic [2:0] subst);
        gp_cycle(sel, 1'b1, 1'b1, subst);
        gp_cycle(sel, 1'b1, 1'b0, subst);
    endtask

    // ----------------------------------------------------------
    // sequence
    // ----------------------------------------------------------
    initial begin : stimulus
        arst_n   = 1'b0;
        reg_sel  = SEL_B;
        {ctl_reg_exx, ctl_reg_ex_af, ctl_reg_ex_de_hl} = 3'b000;
        {ctl_reg_use_ixiy, ctl_reg_use_ix, ctl_reg_use_sp} = 3'b000;
        {ctl_reg_sel_gp, ctl_reg_sel_gp_16} = 2'b00;
        {ctl_reg_sel_wz, ctl_reg_sel_pc, ctl_reg_sel_ir} = 3'b000;
        {ctl_reg_sel_sys_hi, ctl_reg_sel_sys_lo} = 2'b00;
        {ctl_reg_gp_oe, ctl_reg_sys_oe} = 2'b00;
        ctl_sw_4d = 1'b0;
        db_hi_in  = '0;
        db_lo_in  = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // zero after reset, both banks, ix/iy and sp
        for (int p = 0; p < 3; p++)
            sys_cycle(2'(p), 1'b1, 1'b1, 1'b0);
        read_gp_pairs(3'b000);
        pulse(1'b1, 1'b1, 1'b0);
        read_gp_pairs(3'b000);
        pulse(1'b1, 1'b1, 1'b0);
        read_gp_pairs(3'b110);          // ix for hl, af as is
        read_gp_pairs(3'b101);          // iy and sp

        // system pairs, full then hi only then lo only
        for (int p = 0; p < 3; p++) begin
            sys_cycle(2'(p), 1'b1, 1'b1, 1'b1);
            sys_cycle(2'(p), 1'b1, 1'b1, 1'b0);
            sys_cycle(2'(p), 1'b1, 1'b0, 1'b1);
            sys_cycle(2'(p), 1'b1, 1'b1, 1'b0);
            sys_cycle(2'(p), 1'b0, 1'b1, 1'b1);
            sys_cycle(2'(p), 1'b1, 1'b1, 1'b0);
        end

        // gp pairs, 16 bit then every byte B..F
        for (int p = 0; p < 8; p += 2)
            write_read_gp(3'(p), 3'b000);
        for (int s = 0; s < 8; s++) begin
            gp_cycle(3'(s), 1'b0, 1'b1, 3'b000);
            gp_cycle(3'(s), 1'b0, 1'b0, 3'b000);
        end
        read_gp_pairs(3'b000);

        // exchanges, alternates then back to intact mains
        pulse(1'b1, 1'b0, 1'b0);
        for (int p = 0; p < 8; p += 2)
            write_read_gp(3'(p), 3'b000);
        pulse(1'b0, 1'b1, 1'b0);
        write_read_gp(3'd6, 3'b000);
        pulse(1'b1, 1'b1, 1'b0);
        read_gp_pairs(3'b000);
        pulse(1'b1, 1'b1, 1'b0);
        read_gp_pairs(3'b000);
        pulse(1'b1, 1'b1, 1'b0);

        // de/hl swap stays in its own bank
        pulse(1'b0, 1'b0, 1'b1);
        write_read_gp(3'd2, 3'b000);
        write_read_gp(3'd4, 3'b000);
        read_gp_pairs(3'b000);
        pulse(1'b1, 1'b0, 1'b0);
        read_gp_pairs(3'b000);          // alternate bank unswapped
        pulse(1'b0, 1'b0, 1'b1);
        read_gp_pairs(3'b000);
        pulse(1'b1, 1'b0, 1'b0);
        read_gp_pairs(3'b000);

        // substitution with main swap still on, then off
        write_read_gp(3'd2, 3'b110);    // swapped hl, so ix
        write_read_gp(3'd4, 3'b110);
        write_read_gp(3'd2, 3'b100);    // iy
        write_read_gp(3'd6, 3'b001);    // sp
        pulse(1'b0, 1'b0, 1'b1);
        write_read_gp(3'd4, 3'b110);
        write_read_gp(3'd4, 3'b100);
        read_gp_pairs(3'b111);

        start_cycle();
        @(posedge clk);
        @(negedge clk);                 // let the last edge's checks settle
        if (reg_unit_inst.reg_unit_checker_inst.err_flag) begin
            $display("Something failed");
            $fatal(1, "checker flagged an error before the end of the run");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

    // first checker error ends the run
    initial begin : error_watch
        wait (reg_unit_inst.reg_unit_checker_inst.err_flag === 1'b1);
        $display("Something failed");
        $fatal(1, "an assertion in the checker fired");
    end

    initial begin : watchdog
        #((STIM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Something failed");
        $fatal(1, "watchdog expired before the test sequence completed");
    end

endmodule
